// File: alu.sv
// alu: combinational arithmetic, logic and shift unit with a zero flag for branches
`timescale 1ns/1ps

module alu (
  input  cpu_types_pkg::aluop_t op,
  input  cpu_types_pkg::word_t  port_a,
  input  cpu_types_pkg::word_t  port_b,
  output cpu_types_pkg::word_t  port_out,
  output logic                  zero
);

  always_comb begin
    case (op)
      cpu_types_pkg::ALU_ADD: port_out = port_a + port_b;
      cpu_types_pkg::ALU_SUB: port_out = port_a - port_b;
      cpu_types_pkg::ALU_AND: port_out = port_a & port_b;
      cpu_types_pkg::ALU_OR:  port_out = port_a | port_b;
      cpu_types_pkg::ALU_XOR: port_out = port_a ^ port_b;
      // signed compare
      cpu_types_pkg::ALU_SLT: port_out = {31'b0, $signed(port_a) < $signed(port_b)};
      // shift amount from low five bits of b
      cpu_types_pkg::ALU_SLL: port_out = port_a << port_b[4:0];
      cpu_types_pkg::ALU_SRL: port_out = port_a >> port_b[4:0];
      default:                port_out = '0;
    endcase
  end

  // beq/bne use a subtract and look here
  assign zero = (port_out == '0);

endmodule

// File: control_unit.sv
// control unit: decodes an instruction word into the pipeline control struct
`timescale 1ns/1ps

module control_unit (
  input  cpu_types_pkg::word_t instr,
  output cpu_types_pkg::ctrl_t ctrl
);

  cpu_types_pkg::opcode_t op;
  cpu_types_pkg::funct_t  fn;

  assign op = cpu_types_pkg::opcode_t'(instr[31:26]);
  assign fn = cpu_types_pkg::funct_t'(instr[5:0]);

  always_comb begin
    ctrl = '0;
    case (op)
      cpu_types_pkg::RTYPE: begin
        ctrl.reg_wr  = 1'b1;
        ctrl.reg_dst = 1'b1;
        case (fn)
          cpu_types_pkg::SLL: begin
            ctrl.alu_op    = cpu_types_pkg::ALU_SLL;
            ctrl.use_shamt = 1'b1;
          end
          cpu_types_pkg::SRL: begin
            ctrl.alu_op    = cpu_types_pkg::ALU_SRL;
            ctrl.use_shamt = 1'b1;
          end
          cpu_types_pkg::JR: begin
            ctrl.reg_wr  = 1'b0;
            ctrl.reg_dst = 1'b0;
            ctrl.jr      = 1'b1;
          end
          cpu_types_pkg::ADDU: ctrl.alu_op = cpu_types_pkg::ALU_ADD;
          cpu_types_pkg::SUBU: ctrl.alu_op = cpu_types_pkg::ALU_SUB;
          cpu_types_pkg::AND:  ctrl.alu_op = cpu_types_pkg::ALU_AND;
          cpu_types_pkg::OR:   ctrl.alu_op = cpu_types_pkg::ALU_OR;
          cpu_types_pkg::XOR:  ctrl.alu_op = cpu_types_pkg::ALU_XOR;
          cpu_types_pkg::SLT:  ctrl.alu_op = cpu_types_pkg::ALU_SLT;
          // unknown funct becomes a bubble
          default: ctrl = '0;
        endcase
      end
      cpu_types_pkg::ADDIU: begin
        ctrl.alu_op      = cpu_types_pkg::ALU_ADD;
        ctrl.alu_src_imm = 1'b1;
        ctrl.sign_ext    = 1'b1;
        ctrl.reg_wr      = 1'b1;
      end
      cpu_types_pkg::SLTI: begin
        ctrl.alu_op      = cpu_types_pkg::ALU_SLT;
        ctrl.alu_src_imm = 1'b1;
        ctrl.sign_ext    = 1'b1;
        ctrl.reg_wr      = 1'b1;
      end
      // logical immediates are zero extended
      cpu_types_pkg::ANDI: begin
        ctrl.alu_op      = cpu_types_pkg::ALU_AND;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_wr      = 1'b1;
      end
      cpu_types_pkg::ORI: begin
        ctrl.alu_op      = cpu_types_pkg::ALU_OR;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_wr      = 1'b1;
      end
      cpu_types_pkg::LUI: begin
        ctrl.lui    = 1'b1;
        ctrl.reg_wr = 1'b1;
      end
      cpu_types_pkg::LW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.sign_ext    = 1'b1;
        ctrl.reg_wr      = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
        ctrl.mem_rd      = 1'b1;
      end
      cpu_types_pkg::SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.sign_ext    = 1'b1;
        ctrl.mem_wr      = 1'b1;
      end
      cpu_types_pkg::BEQ: begin
        ctrl.alu_op   = cpu_types_pkg::ALU_SUB;
        ctrl.sign_ext = 1'b1;
        ctrl.beq      = 1'b1;
      end
      cpu_types_pkg::BNE: begin
        ctrl.alu_op   = cpu_types_pkg::ALU_SUB;
        ctrl.sign_ext = 1'b1;
        ctrl.bne      = 1'b1;
      end
      cpu_types_pkg::J:   ctrl.jump = 1'b1;
      cpu_types_pkg::JAL: begin
        ctrl.jal    = 1'b1;
        ctrl.reg_wr = 1'b1;
      end
      cpu_types_pkg::HALT: ctrl.halt = 1'b1;
      default: ctrl = '0;
    endcase
  end

endmodule

// File: cpu_top.sv
// cpu top: pipelined datapath joined to the shared memory bus through the request unit
`timescale 1ns/1ps

module cpu_top #(
  parameter cpu_types_pkg::word_t PC_INIT = 32'h0000_0000
) (
  input  logic                 CLK,
  input  logic                 nRST,
  output logic                 ram_ren,
  output logic                 ram_wen,
  output cpu_types_pkg::word_t ram_addr,
  output cpu_types_pkg::word_t ram_store,
  input  cpu_types_pkg::word_t ram_load,
  input  logic                 ram_ready,
  output logic                 halt
);

  // hit-based link between the core and the request unit
  logic                 ihit;
  logic                 dhit;
  logic                 imem_ren;
  logic                 dmem_ren;
  logic                 dmem_wen;
  cpu_types_pkg::word_t imem_load;
  cpu_types_pkg::word_t dmem_load;
  cpu_types_pkg::word_t imem_addr;
  cpu_types_pkg::word_t dmem_addr;
  cpu_types_pkg::word_t dmem_store;

  datapath #(
    .PC_INIT (PC_INIT)
  ) u_dp (
    .CLK        (CLK),
    .nRST       (nRST),
    .ihit       (ihit),
    .dhit       (dhit),
    .imem_load  (imem_load),
    .dmem_load  (dmem_load),
    .imem_ren   (imem_ren),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .imem_addr  (imem_addr),
    .dmem_addr  (dmem_addr),
    .dmem_store (dmem_store),
    .halt       (halt)
  );

  memory_request_unit u_mru (
    .CLK        (CLK),
    .nRST       (nRST),
    .imem_ren   (imem_ren),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .imem_addr  (imem_addr),
    .dmem_addr  (dmem_addr),
    .dmem_store (dmem_store),
    .ihit       (ihit),
    .dhit       (dhit),
    .imem_load  (imem_load),
    .dmem_load  (dmem_load),
    .ram_ren    (ram_ren),
    .ram_wen    (ram_wen),
    .ram_addr   (ram_addr),
    .ram_store  (ram_store),
    .ram_load   (ram_load),
    .ram_ready  (ram_ready)
  );

endmodule

// File: cpu_types_pkg.sv
// cpu types: instruction encodings, word types and pipeline latch structs for the MIPS core
package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // primary opcodes, instr[31:26]
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDIU = 6'b001001,
    SLTI  = 6'b001010,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  // r-type function codes, instr[5:0]
  typedef enum logic [5:0] {
    SLL  = 6'b000000,
    SRL  = 6'b000010,
    JR   = 6'b001000,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    XOR  = 6'b100110,
    SLT  = 6'b101010
  } funct_t;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLT = 4'd5,
    ALU_SLL = 4'd6,
    ALU_SRL = 4'd7
  } aluop_t;

  // decoded controls, all zero for a bubble
  typedef struct packed {
    aluop_t alu_op;
    logic   alu_src_imm;
    logic   sign_ext;
    logic   use_shamt;
    logic   reg_wr;
    logic   reg_dst;
    logic   mem_to_reg;
    logic   mem_rd;
    logic   mem_wr;
    logic   beq;
    logic   bne;
    logic   jump;
    logic   jal;
    logic   jr;
    logic   lui;
    logic   halt;
  } ctrl_t;

  // ------------------------------
  // pipeline latches
  // ------------------------------
  typedef struct packed {
    word_t instr;
    word_t pc_plus4;
    logic  valid;
  } fd_latch_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    rdat1;
    word_t    rdat2;
    word_t    ext_imm;
    logic [4:0] shamt;
    regbits_t rs;
    regbits_t rt;
    regbits_t wsel;
    word_t    pc_plus4;
    word_t    jump_target;
    logic     valid;
  } de_latch_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    alu_out;
    logic     zero;
    word_t    rdat1;
    word_t    rdat2;
    word_t    ext_imm;
    regbits_t wsel;
    word_t    pc_plus4;
    word_t    jump_target;
    logic     valid;
  } em_latch_t;

  typedef struct packed {
    logic     reg_wr;
    logic     halt;
    word_t    wdat;
    regbits_t wsel;
  } mw_latch_t;

endpackage

// File: datapath.sv
// datapath: five-stage pipeline with pc, stage latches, extenders, muxes and halt latch
`timescale 1ns/1ps

module datapath #(
  parameter cpu_types_pkg::word_t PC_INIT = 32'h0000_0000
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 ihit,
  input  logic                 dhit,
  input  cpu_types_pkg::word_t imem_load,
  input  cpu_types_pkg::word_t dmem_load,
  output logic                 imem_ren,
  output logic                 dmem_ren,
  output logic                 dmem_wen,
  output cpu_types_pkg::word_t imem_addr,
  output cpu_types_pkg::word_t dmem_addr,
  output cpu_types_pkg::word_t dmem_store,
  output logic                 halt
);

  cpu_types_pkg::word_t pc;
  cpu_types_pkg::word_t pc_next;
  cpu_types_pkg::word_t pc_plus4;

  cpu_types_pkg::fd_latch_t fd;
  cpu_types_pkg::fd_latch_t fd_next;
  cpu_types_pkg::de_latch_t de;
  cpu_types_pkg::de_latch_t de_next;
  cpu_types_pkg::em_latch_t em;
  cpu_types_pkg::em_latch_t em_next;
  cpu_types_pkg::mw_latch_t mw;
  cpu_types_pkg::mw_latch_t mw_next;

  cpu_types_pkg::ctrl_t   dec_ctrl;
  cpu_types_pkg::word_t   rdat1;
  cpu_types_pkg::word_t   rdat2;
  cpu_types_pkg::word_t   dec_imm;
  cpu_types_pkg::regbits_t dec_wsel;
  logic                   uses_rt;

  cpu_types_pkg::word_t alu_a;
  cpu_types_pkg::word_t alu_b;
  cpu_types_pkg::word_t alu_out;
  logic                 alu_zero;

  cpu_types_pkg::word_t branch_target;
  cpu_types_pkg::word_t xfer_target;
  cpu_types_pkg::word_t wb_dat;
  cpu_types_pkg::word_t load_q;

  logic stall;
  logic flush;
  logic draining;
  logic front_hold;
  logic mem_access;
  logic data_done;
  logic advance;

  // ------------------------------
  // fetch
  // ------------------------------
  assign pc_plus4  = pc + 32'd4;
  assign imem_addr = pc;
  assign imem_ren  = !halt;

  // an older halt in flight keeps younger work out of the pipe
  assign draining   = de.ctrl.halt || em.ctrl.halt || mw.halt;
  assign front_hold = stall || draining;

  always_comb begin
    if (flush) begin
      pc_next = xfer_target;
      fd_next = '0;
    end else if (front_hold) begin
      pc_next = pc;
      fd_next = fd;
    end else begin
      pc_next          = pc_plus4;
      fd_next.instr    = imem_load;
      fd_next.pc_plus4 = pc_plus4;
      fd_next.valid    = 1'b1;
    end
  end

  // ------------------------------
  // decode
  // ------------------------------
  control_unit u_cu (
    .instr (fd.instr),
    .ctrl  (dec_ctrl)
  );

  register_file u_rf (
    .CLK   (CLK),
    .nRST  (nRST),
    .wen   (mw.reg_wr),
    .wsel  (mw.wsel),
    .wdat  (mw.wdat),
    .rsel1 (fd.instr[25:21]),
    .rsel2 (fd.instr[20:16]),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  assign dec_imm = dec_ctrl.sign_ext ? {{16{fd.instr[15]}}, fd.instr[15:0]}
                                     : {16'h0000, fd.instr[15:0]};
  assign dec_wsel = dec_ctrl.jal     ? 5'd31 :
                    dec_ctrl.reg_dst ? fd.instr[15:11] : fd.instr[20:16];
  // rt is a source for r-type, stores and branches
  assign uses_rt = dec_ctrl.reg_dst || dec_ctrl.mem_wr || dec_ctrl.beq || dec_ctrl.bne;

  hazard_unit u_hu (
    .rs         (fd.instr[25:21]),
    .rt         (fd.instr[20:16]),
    .uses_rt    (uses_rt),
    .ex_wsel    (de.wsel),
    .mem_wsel   (em.wsel),
    .ex_reg_wr  (de.ctrl.reg_wr),
    .mem_reg_wr (em.ctrl.reg_wr),
    .ex_mem     (em),
    .stall      (stall),
    .flush      (flush)
  );

  always_comb begin
    de_next = '0;
    if (!flush && !front_hold && fd.valid) begin
      de_next.ctrl        = dec_ctrl;
      de_next.rdat1       = rdat1;
      de_next.rdat2       = rdat2;
      de_next.ext_imm     = dec_imm;
      de_next.shamt       = fd.instr[10:6];
      de_next.rs          = fd.instr[25:21];
      de_next.rt          = fd.instr[20:16];
      de_next.wsel        = dec_wsel;
      de_next.pc_plus4    = fd.pc_plus4;
      de_next.jump_target = {fd.pc_plus4[31:28], fd.instr[25:0], 2'b00};
      de_next.valid       = 1'b1;
    end
  end

  // ------------------------------
  // execute
  // ------------------------------
  // shifts move rt by shamt
  assign alu_a = de.ctrl.use_shamt ? de.rdat2 : de.rdat1;
  assign alu_b = de.ctrl.use_shamt   ? {27'b0, de.shamt} :
                 de.ctrl.alu_src_imm ? de.ext_imm : de.rdat2;

  alu u_alu (
    .op       (de.ctrl.alu_op),
    .port_a   (alu_a),
    .port_b   (alu_b),
    .port_out (alu_out),
    .zero     (alu_zero)
  );

  always_comb begin
    em_next = '0;
    if (!flush && de.valid) begin
      em_next.ctrl        = de.ctrl;
      em_next.alu_out     = alu_out;
      em_next.zero        = alu_zero;
      em_next.rdat1       = de.rdat1;
      em_next.rdat2       = de.rdat2;
      em_next.ext_imm     = de.ext_imm;
      em_next.wsel        = de.wsel;
      em_next.pc_plus4    = de.pc_plus4;
      em_next.jump_target = de.jump_target;
      em_next.valid       = 1'b1;
    end
  end

  // ------------------------------
  // memory
  // ------------------------------
  assign mem_access = em.valid && (em.ctrl.mem_rd || em.ctrl.mem_wr);
  // request drops once served, the fetch then gets the bus
  assign dmem_ren   = em.valid && em.ctrl.mem_rd && !data_done && !halt;
  assign dmem_wen   = em.valid && em.ctrl.mem_wr && !data_done && !halt;
  assign dmem_addr  = em.alu_out;
  assign dmem_store = em.rdat2;

  assign branch_target = em.pc_plus4 + {em.ext_imm[29:0], 2'b00};
  assign xfer_target   = em.ctrl.jr ? em.rdat1 :
                         (em.ctrl.jump || em.ctrl.jal) ? em.jump_target : branch_target;

  always_comb begin
    if (em.ctrl.lui) begin
      wb_dat = {em.ext_imm[15:0], 16'h0000};
    end else if (em.ctrl.jal) begin
      wb_dat = em.pc_plus4;
    end else if (em.ctrl.mem_to_reg) begin
      wb_dat = load_q;
    end else begin
      wb_dat = em.alu_out;
    end
  end

  assign mw_next.reg_wr = em.valid && em.ctrl.reg_wr;
  assign mw_next.halt   = em.valid && em.ctrl.halt;
  assign mw_next.wdat   = wb_dat;
  assign mw_next.wsel   = em.wsel;

  // hits never share a cycle, so a served data access is remembered
  assign advance = ihit && (!mem_access || data_done);

  // ------------------------------
  // state
  // ------------------------------
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
      fd <= '0;
      de <= '0;
      em <= '0;
      mw <= '0;
    end else if (advance) begin
      pc <= pc_next;
      fd <= fd_next;
      de <= de_next;
      em <= em_next;
      mw <= mw_next;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      data_done <= 1'b0;
    end else if (advance) begin
      data_done <= 1'b0;
    end else if (dhit) begin
      data_done <= 1'b1;
    end
  end

  // load word held until the stage moves on
  always_ff @(posedge CLK) begin
    if (dhit) begin
      load_q <= dmem_load;
    end
  end

  // sticky until reset
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (mw.halt) begin
      halt <= 1'b1;
    end
  end

endmodule

// File: hazard_unit.sv
// hazard unit: decode stall on read-after-write dependencies and flush on taken transfers
`timescale 1ns/1ps

module hazard_unit (
  input  cpu_types_pkg::regbits_t  rs,
  input  cpu_types_pkg::regbits_t  rt,
  input  logic                     uses_rt,
  input  cpu_types_pkg::regbits_t  ex_wsel,
  input  cpu_types_pkg::regbits_t  mem_wsel,
  input  logic                     ex_reg_wr,
  input  logic                     mem_reg_wr,
  input  cpu_types_pkg::em_latch_t ex_mem,
  output logic                     stall,
  output logic                     flush
);

  logic ex_dep;
  logic mem_dep;
  logic taken;

  // no forwarding, so wait until the producer reaches writeback
  assign ex_dep = ex_reg_wr && ex_wsel != 5'd0 &&
                  (ex_wsel == rs || (uses_rt && ex_wsel == rt));
  assign mem_dep = mem_reg_wr && mem_wsel != 5'd0 &&
                   (mem_wsel == rs || (uses_rt && mem_wsel == rt));

  // the one place a transfer is judged taken
  assign taken = ex_mem.valid &&
                 ((ex_mem.ctrl.beq && ex_mem.zero) ||
                  (ex_mem.ctrl.bne && !ex_mem.zero) ||
                  ex_mem.ctrl.jump || ex_mem.ctrl.jal || ex_mem.ctrl.jr);

  assign flush = taken;
  // decode gets squashed anyway on a flush
  assign stall = (ex_dep || mem_dep) && !taken;

endmodule

// File: memory_request_unit.sv
// memory request unit: puts fetch and data requests onto one memory bus, data first
`timescale 1ns/1ps

module memory_request_unit (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 imem_ren,
  input  logic                 dmem_ren,
  input  logic                 dmem_wen,
  input  cpu_types_pkg::word_t imem_addr,
  input  cpu_types_pkg::word_t dmem_addr,
  input  cpu_types_pkg::word_t dmem_store,
  output logic                 ihit,
  output logic                 dhit,
  output cpu_types_pkg::word_t imem_load,
  output cpu_types_pkg::word_t dmem_load,
  output logic                 ram_ren,
  output logic                 ram_wen,
  output cpu_types_pkg::word_t ram_addr,
  output cpu_types_pkg::word_t ram_store,
  input  cpu_types_pkg::word_t ram_load,
  input  logic                 ram_ready
);

  logic dreq;
  logic d_pend;

  assign dreq = dmem_ren || dmem_wen;

  // ------------------------------
  // bus select
  // ------------------------------
  assign ram_ren   = dreq ? dmem_ren : imem_ren;
  assign ram_wen   = dmem_wen;
  assign ram_addr  = dreq ? dmem_addr : imem_addr;
  assign ram_store = dmem_store;

  // ready goes back to whoever owns the bus this cycle
  assign dhit = dreq && ram_ready;
  // a data access left waiting last cycle blocks any fetch completion
  assign ihit = imem_ren && !dreq && !d_pend && ram_ready;

  assign imem_load = ram_load;
  assign dmem_load = ram_load;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      d_pend <= 1'b0;
    end else begin
      d_pend <= dreq && !ram_ready;
    end
  end

endmodule

// File: pipeline_cpu.f
cpu_types_pkg.sv
alu.sv
control_unit.sv
register_file.sv
hazard_unit.sv
datapath.sv
memory_request_unit.sv
cpu_top.sv
tb_cpu_top.sv

// File: register_file.sv
// register file: 32 x 32-bit registers, r0 reads zero, same-cycle write passes to the reads
`timescale 1ns/1ps

module register_file (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::word_t    wdat,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);

  cpu_types_pkg::word_t regs [32];

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wsel != 5'd0) begin
      regs[wsel] <= wdat;
    end
  end

  // writeback value bypasses the array so decode never waits on it
  assign rdat1 = (rsel1 == 5'd0) ? '0 :
                 (wen && rsel1 == wsel) ? wdat : regs[rsel1];
  assign rdat2 = (rsel2 == 5'd0) ? '0 :
                 (wen && rsel2 == wsel) ? wdat : regs[rsel2];

endmodule

// File: tb_cpu_top.sv
// testbench for cpu_top: memory model with wait states, program loader and directed tests
`timescale 1ns/1ps

module tb_cpu_top;

  localparam cpu_types_pkg::word_t PC_INIT = 32'h0000_0040;
  localparam int DATA_BASE = 32'h400;
  localparam int HALT_LIMIT = 4000;

  logic                 CLK;
  logic                 nRST;
  logic                 ram_ren;
  logic                 ram_wen;
  cpu_types_pkg::word_t ram_addr;
  cpu_types_pkg::word_t ram_store;
  cpu_types_pkg::word_t ram_load;
  logic                 ram_ready;
  logic                 halt;

  cpu_types_pkg::word_t mem [512];
  cpu_types_pkg::word_t prog [$];
  logic                 rand_waits;
  int                   wait_cnt = 0;
  int                   wait_target = 0;

  cpu_top #(
    .PC_INIT (PC_INIT)
  ) uut (
    .CLK       (CLK),
    .nRST      (nRST),
    .ram_ren   (ram_ren),
    .ram_wen   (ram_wen),
    .ram_addr  (ram_addr),
    .ram_store (ram_store),
    .ram_load  (ram_load),
    .ram_ready (ram_ready),
    .halt      (halt)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // ------------------------------
  // memory model
  // ------------------------------
  function int pick_wait();
    if (rand_waits) begin
      return $urandom_range(3, 0);
    end else begin
      return 0;
    end
  endfunction

  // ready and read data move on the falling edge
  always @(negedge CLK) begin
    if (ram_ren === 1'b1 || ram_wen === 1'b1) begin
      if (wait_cnt >= wait_target) begin
        ram_ready   <= 1'b1;
        ram_load    <= mem[ram_addr[10:2]];
        wait_cnt    <= 0;
        wait_target <= pick_wait();
      end else begin
        ram_ready <= 1'b0;
        wait_cnt  <= wait_cnt + 1;
      end
    end else begin
      ram_ready <= 1'b0;
    end
  end

  // store lands on the edge that completes it
  always @(posedge CLK) begin
    if (ram_wen === 1'b1 && ram_ready === 1'b1) begin
      mem[ram_addr[10:2]] <= ram_store;
    end
  end

  // ------------------------------
  // compare tasks
  // ------------------------------
  task check_word(input string name, input cpu_types_pkg::word_t actual,
                  input cpu_types_pkg::word_t expected);
    if (actual !== expected) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("error at %0t: %s is %b, expected %b", $time, name, actual, expected);
      $display("TB FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task check_mem(input int k, input cpu_types_pkg::word_t expected);
    int byte_addr;
    byte_addr = DATA_BASE + 4 * k;
    check_word($sformatf("mem[%h]", byte_addr), mem[byte_addr[10:2]], expected);
  endtask

  // ------------------------------
  // assembler helpers
  // ------------------------------
  function cpu_types_pkg::word_t enc_r(cpu_types_pkg::funct_t fn, cpu_types_pkg::regbits_t rs,
                                       cpu_types_pkg::regbits_t rt,
                                       cpu_types_pkg::regbits_t rd, logic [4:0] sh);
    return {6'b000000, rs, rt, rd, sh, fn};
  endfunction

  function cpu_types_pkg::word_t enc_i(cpu_types_pkg::opcode_t op, cpu_types_pkg::regbits_t rs,
                                       cpu_types_pkg::regbits_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function cpu_types_pkg::word_t enc_j(cpu_types_pkg::opcode_t op,
                                       cpu_types_pkg::word_t target);
    return {op, target[27:2]};
  endfunction

  function cpu_types_pkg::word_t sext16(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  // program at PC_INIT, everything else zero (a nop)
  task load_program();
    for (int i = 0; i < 512; i++) begin
      mem[i] = '0;
    end
    foreach (prog[i]) begin
      mem[(PC_INIT >> 2) + i] = prog[i];
    end
  endtask

  // ------------------------------
  // run control
  // ------------------------------
  task reset_dut();
    @(negedge CLK);
    nRST = 1'b0;
    repeat (8) begin
      @(negedge CLK);
      check_flag("halt", halt, 1'b0);
      check_flag("ram_wen", ram_wen, 1'b0);
    end
    // first fetch is sitting on the bus
    check_flag("ram_ren", ram_ren, 1'b1);
    check_word("ram_addr", ram_addr, PC_INIT);
    nRST = 1'b1;
  endtask

  task wait_halt(input string test);
    int cycles;
    cycles = 0;
    while (halt !== 1'b1 && cycles < HALT_LIMIT) begin
      @(negedge CLK);
      cycles++;
    end
    if (halt !== 1'b1) begin
      $display("timeout: %s did not halt within %0d cycles", test, HALT_LIMIT);
      $display("TB FAILED");
      $fatal(1, "halt timeout");
    end
  endtask

  // bus stays quiet once halted
  task check_quiet();
    repeat (20) begin
      @(negedge CLK);
      check_flag("ram_wen", ram_wen, 1'b0);
      check_flag("ram_ren", ram_ren, 1'b0);
      check_flag("halt", halt, 1'b1);
    end
  endtask

  task run_program(input string test);
    load_program();
    reset_dut();
    wait_halt(test);
    check_quiet();
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task test_alu_imm();
    cpu_types_pkg::word_t r1, r2, r3;
    cpu_types_pkg::word_t ev [12];
    prog.delete();
    prog.push_back(enc_i(cpu_types_pkg::ORI, 0, 1, 16'h1234));
    prog.push_back(enc_i(cpu_types_pkg::LUI, 0, 2, 16'h8001));
    prog.push_back(enc_i(cpu_types_pkg::ORI, 2, 2, 16'h00f0));
    prog.push_back(enc_i(cpu_types_pkg::ADDIU, 0, 3, 16'hfffb));
    prog.push_back(enc_r(cpu_types_pkg::ADDU, 1, 2, 4, 0));
    prog.push_back(enc_r(cpu_types_pkg::SUBU, 1, 2, 5, 0));
    prog.push_back(enc_r(cpu_types_pkg::AND, 2, 3, 6, 0));
    prog.push_back(enc_r(cpu_types_pkg::OR, 1, 3, 7, 0));
    prog.push_back(enc_r(cpu_types_pkg::XOR, 1, 2, 8, 0));
    prog.push_back(enc_r(cpu_types_pkg::SLT, 2, 1, 9, 0));
    prog.push_back(enc_i(cpu_types_pkg::SLTI, 3, 10, 16'hfffc));
    prog.push_back(enc_i(cpu_types_pkg::ANDI, 3, 11, 16'hff0f));
    prog.push_back(enc_r(cpu_types_pkg::SLL, 0, 1, 12, 5'd4));
    prog.push_back(enc_r(cpu_types_pkg::SRL, 0, 2, 13, 5'd8));
    for (int k = 0; k < 12; k++) begin
      prog.push_back(enc_i(cpu_types_pkg::SW, 0, 5'(k + 2), 16'(DATA_BASE + 4 * k)));
    end
    prog.push_back({cpu_types_pkg::HALT, 26'd0});
    run_program("alu and immediates");
    r1 = 32'h0000_1234;
    r2 = {16'h8001, 16'h0000} | 32'h0000_00f0;
    r3 = sext16(16'hfffb);
    ev[0]  = r2;
    ev[1]  = r3;
    ev[2]  = r1 + r2;
    ev[3]  = r1 - r2;
    ev[4]  = r2 & r3;
    ev[5]  = r1 | r3;
    ev[6]  = r1 ^ r2;
    ev[7]  = ($signed(r2) < $signed(r1)) ? 32'd1 : 32'd0;
    ev[8]  = ($signed(r3) < $signed(sext16(16'hfffc))) ? 32'd1 : 32'd0;
    ev[9]  = r3 & 32'h0000_ff0f;
    ev[10] = r1 << 4;
    ev[11] = r2 >> 8;
    for (int k = 0; k < 12; k++) begin
      check_mem(k, ev[k]);
    end
  endtask

  task test_dependency();
    cpu_types_pkg::word_t v1, v2, v3, v4, pre;
    pre = 32'h1357_9bdf;
    prog.delete();
    prog.push_back(enc_i(cpu_types_pkg::ADDIU, 0, 1, 16'd7));
    prog.push_back(enc_r(cpu_types_pkg::ADDU, 1, 1, 2, 0));
    prog.push_back(enc_r(cpu_types_pkg::ADDU, 2, 1, 3, 0));
    prog.push_back(enc_r(cpu_types_pkg::SUBU, 3, 2, 4, 0));
    prog.push_back(enc_i(cpu_types_pkg::SW, 0, 4, 16'h0400));
    prog.push_back(enc_i(cpu_types_pkg::LW, 0, 5, 16'h0400));
    // load followed straight away by its use
    prog.push_back(enc_r(cpu_types_pkg::ADDU, 5, 3, 6, 0));
    prog.push_back(enc_i(cpu_types_pkg::SW, 0, 6, 16'h0404));
    prog.push_back(enc_i(cpu_types_pkg::ADDIU, 0, 7, 16'h0055));
    prog.push_back(enc_i(cpu_types_pkg::SW, 0, 7, 16'h0408));
    prog.push_back(enc_i(cpu_types_pkg::LW, 0, 8, 16'h0408));
    prog.push_back(enc_i(cpu_types_pkg::SW, 0, 8, 16'h040c));
    prog.push_back(enc_i(cpu_types_pkg::LW, 0, 9, 16'h0410));
    prog.push_back(enc_i(cpu_types_pkg::ADDIU, 9, 10, 16'd1));
    prog.push_back(enc_i(cpu_types_pkg::SW, 0, 10, 16'h0414));
    prog.push_back({cpu_types_pkg::HALT, 26'd0});
    load_program();
    mem[(DATA_BASE + 16) >> 2] = pre;
    reset_dut();
    wait_halt("dependency chains");
    check_quiet();
    v1 = 32'd7;
    v2 = v1 + v1;
    v3 = v2 + v1;
    v4 = v3 - v2;
    check_mem(0, v4);
    check_mem(1, v4 + v3);
    check_mem(2, 32'h55);
    check_mem(3, 32'h55);
    check_mem(4, pre);
    check_mem(5, pre + 32'd1);
  endtask

  task test_control_flow();
    cpu_types_pkg::word_t ev [17];
    prog.delete();
    prog.push_back(enc_i(cpu_types_pkg::ADDIU, 0, 1, 16'd3));
    prog.push_back(enc_i(cpu_types_pkg::ADDIU, 0, 2, 16'd3));
    prog.push_back(enc_i(cpu_types_pkg::ADDIU, 0, 9, 16'h0099));
    prog.push_back(enc_i(cpu_types_pkg::BEQ, 1, 2, 16'd3));
    for (int k = 0; k < 3; k++) begin
      prog.push_back(enc_i(cpu_types_pkg::SW, 0, 9, 16'(DATA_BASE + 4 * k)));
    end
    // untaken pair, a wrong take skips the marker
    prog.push_back(enc_i(cpu_types_pkg::BNE, 1, 2, 16'd1));
    prog.push_back(enc_i(cpu_types_pkg::ORI, 0, 3, 16'h0011));
    prog.push_back(enc_i(cpu_types_pkg::SW, 0, 3, 16'h040c));
    prog.push_back(enc_i(cpu_types_pkg::BEQ, 1, 0, 16'd1));
    prog.push_back(enc_i(cpu_types_pkg::ORI, 0, 4, 16'h0022));
    prog.push_back(enc_i(cpu_types_pkg::SW, 0, 4, 16'h0410));
    prog.push_back(enc_i(cpu_types_pkg::BNE, 1, 0, 16'd3));
    for (int k = 5; k < 8; k++) begin
      prog.push_back(enc_i(cpu_types_pkg::SW, 0, 9, 16'(DATA_BASE + 4 * k)));
    end
    prog.push_back(enc_j(cpu_types_pkg::J, PC_INIT + 4 * 21));
    for (int k = 8; k < 11; k++) begin
      prog.push_back(enc_i(cpu_types_pkg::SW, 0, 9, 16'(DATA_BASE + 4 * k)));
    end
    prog.push_back(enc_j(cpu_types_pkg::JAL, PC_INIT + 4 * 27));
    // return lands here at index 22
    prog.push_back(enc_i(cpu_types_pkg::SW, 0, 31, 16'h042c));
    prog.push_back(enc_i(cpu_types_pkg::ORI, 0, 5, 16'h0033));
    prog.push_back(enc_i(cpu_types_pkg::SW, 0, 5, 16'h0430));
    prog.push_back({cpu_types_pkg::HALT, 26'd0});
    prog.push_back(32'h0000_0000);
    prog.push_back(enc_i(cpu_types_pkg::ADDIU, 0, 6, 16'h0044));
    prog.push_back(enc_i(cpu_types_pkg::SW, 0, 6, 16'h0434));
    prog.push_back(enc_r(cpu_types_pkg::JR, 31, 0, 0, 0));
    for (int k = 14; k < 17; k++) begin
      prog.push_back(enc_i(cpu_types_pkg::SW, 0, 9, 16'(DATA_BASE + 4 * k)));
    end
    run_program("control flow");
    for (int k = 0; k < 17; k++) begin
      ev[k] = '0;
    end
    ev[3]  = 32'h11;
    ev[4]  = 32'h22;
    ev[11] = PC_INIT + 4 * 22;
    ev[12] = 32'h33;
    ev[13] = 32'h44;
    for (int k = 0; k < 17; k++) begin
      check_mem(k, ev[k]);
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    void'($urandom(32'h9b1d_25ba));
    nRST       = 1'b0;
    ram_ready  = 1'b0;
    ram_load   = '0;
    rand_waits = 1'b0;
    test_alu_imm();
    test_dependency();
    test_control_flow();
    // same programs under back-pressure
    rand_waits = 1'b1;
    test_alu_imm();
    test_dependency();
    test_control_flow();
    $display("TB PASSED");
    $finish;
  end

endmodule
